//--- core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

//////////////////////////////
// datapath
//////////////////////////////

`define XLEN 32        // integer data width

`define NUM_REGS 16    // architectural registers, r0 hardwired to zero

//////////////////////////////
// backend sizing
//////////////////////////////

`define ROB_SIZE 8     // power of two

// one quotient bit per iteration
`define DIV_CYCLES 32

`endif

//--- corePkg.sv
`include "core_defines.svh"

package corePkg;

    typedef logic [$clog2(`NUM_REGS)-1:0] RegIdx;

    typedef logic [$clog2(`ROB_SIZE):0] SqN;  // extra wrap bit for full/empty

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } Opcode;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } DivState;

    typedef struct packed {
        logic valid;
        Opcode opcode;
        RegIdx dst;
        RegIdx src1;
        RegIdx src2;
        logic useImm;
        logic [11:0] imm;
    } InUOp;

    typedef struct packed {
        logic valid;
        Opcode opcode;
        SqN sqN;
        RegIdx dst;
        logic [`XLEN-1:0] opA;
        logic [`XLEN-1:0] opB;  // register or sign-extended imm
    } IssueUOp;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RegIdx dst;
        logic [`XLEN-1:0] result;
    } ResultUOp;

    typedef struct packed {
        logic divBusy;
        logic wbReserved;
    } PortStatus;

    typedef struct packed {
        SqN sqN;
        RegIdx dst;
        logic [`XLEN-1:0] result;
    } CommitUOp;

endpackage

//--- intAlu.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module intAlu
(
    input corePkg::Opcode opcode,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);
    import corePkg::*;

    logic [4:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign shamt = b[4:0];  // low 5 bits only
    assign lessSigned = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (opcode)
            OP_ADD: y = a + b;
            OP_SUB: y = a - b;
            OP_AND: y = a & b;
            OP_OR: y = a | b;
            OP_XOR: y = a ^ b;
            OP_SLL: y = a << shamt;
            OP_SRL: y = a >> shamt;
            OP_SRA: y = $signed(a) >>> shamt;
            OP_SLT: y = {{(`XLEN-1){1'b0}}, lessSigned};
            OP_SLTU: y = {{(`XLEN-1){1'b0}}, lessUnsigned};
            default: y = '0;  // divides go to the divider
        endcase
    end

endmodule

//--- divider.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module divider
(
    input logic clk,
    input logic rstN,
    input logic start,
    input corePkg::Opcode opcode,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b,
    output logic busy,
    output logic finishing,
    output logic done,
    output logic [`XLEN-1:0] y
);
    import corePkg::*;

    typedef logic [$clog2(`DIV_CYCLES)-1:0] DivCnt;

    DivState state;
    DivCnt count;
    logic [`XLEN-1:0] rem;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] dvsr;
    logic negQ;
    logic negR;
    logic wantRem;

    logic launch;
    logic isSigned;
    logic [`XLEN-1:0] magA;
    logic [`XLEN-1:0] magB;
    logic [2*`XLEN-1:0] firstStep;
    logic [2*`XLEN-1:0] nextStep;

    // one restoring step, returns {rem, quo}
    function automatic logic [2*`XLEN-1:0] divStep(
        input logic [`XLEN-1:0] r,
        input logic [`XLEN-1:0] q,
        input logic [`XLEN-1:0] d
    );
        logic [`XLEN:0] trial;
        logic [`XLEN-1:0] newR;
        trial = {r, q[`XLEN-1]} - {1'b0, d};
        newR = trial[`XLEN] ? {r[`XLEN-2:0], q[`XLEN-1]} : trial[`XLEN-1:0];
        return {newR, q[`XLEN-2:0], !trial[`XLEN]};
    endfunction

    always_comb begin
        launch = start && (state != RUN);
        isSigned = opcode inside {OP_DIV, OP_REM};
        magA = (isSigned && a[`XLEN-1]) ? -a : a;
        magB = (isSigned && b[`XLEN-1]) ? -b : b;
        firstStep = divStep('0, magA, magB);  // first iteration at launch
        nextStep = divStep(rem, quo, dvsr);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: state <= start ? RUN : IDLE;
                RUN: state <= finishing ? DONE : RUN;
                default: state <= start ? RUN : IDLE;  // back to back allowed
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            {rem, quo} <= firstStep;
            dvsr <= magB;
            count <= DivCnt'(1);
            negQ <= isSigned && (a[`XLEN-1] ^ b[`XLEN-1]) && (b != '0);  // x/0 stays all ones
            negR <= isSigned && a[`XLEN-1];
            wantRem <= opcode inside {OP_REM, OP_REMU};
        end else if (state == RUN) begin
            {rem, quo} <= nextStep;
            count <= count + 1'b1;
        end
    end

    assign busy = (state == RUN);
    assign finishing = busy && (count == DivCnt'(`DIV_CYCLES - 1));
    assign done = (state == DONE);
    assign y = wantRem ? (negR ? -rem : rem) : (negQ ? -quo : quo);

endmodule

//--- execPort.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execPort
(
    input logic clk,
    input logic rstN,
    input corePkg::IssueUOp issueUOp,
    output corePkg::PortStatus portStatus,
    output corePkg::ResultUOp result
);
    import corePkg::*;

    logic isDiv;
    logic divStart;
    logic divBusy;
    logic divFinishing;
    logic divDone;
    logic [`XLEN-1:0] aluY;
    logic [`XLEN-1:0] divY;
    SqN divSqN;  // tags of the division in flight
    RegIdx divDst;

    assign isDiv = issueUOp.opcode inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign divStart = issueUOp.valid && isDiv;

    intAlu alu_i
    (
        .opcode(issueUOp.opcode),
        .a(issueUOp.opA),
        .b(issueUOp.opB),
        .y(aluY)
    );

    divider div_i
    (
        .clk(clk),
        .rstN(rstN),
        .start(divStart),
        .opcode(issueUOp.opcode),
        .a(issueUOp.opA),
        .b(issueUOp.opB),
        .busy(divBusy),
        .finishing(divFinishing),
        .done(divDone),
        .y(divY)
    );

    assign portStatus.divBusy = divBusy || divStart;
    assign portStatus.wbReserved = divFinishing;  // divider owns next writeback

    always_ff @(posedge clk) begin
        if (divStart) begin
            divSqN <= issueUOp.sqN;
            divDst <= issueUOp.dst;
        end
    end

    //////////////////////////////
    // writeback select
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= divDone || (issueUOp.valid && !isDiv);
            if (divDone) begin
                result.sqN <= divSqN;
                result.dst <= divDst;
                result.result <= divY;
            end else begin
                result.sqN <= issueUOp.sqN;
                result.dst <= issueUOp.dst;
                result.result <= aluY;
            end
        end
    end

endmodule

//--- dispatchStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module dispatchStage
(
    input logic clk,
    input logic rstN,

    input corePkg::InUOp inUOp,
    output logic inStall,

    input corePkg::PortStatus portStatus,
    input logic robFull,

    input logic retireValid,
    input corePkg::CommitUOp retireUOp,

    output corePkg::IssueUOp issueUOp
);
    import corePkg::*;

    logic [`XLEN-1:0] regFile [`NUM_REGS];
    logic [`NUM_REGS-1:0] pending;  // scoreboard, one bit per register
    SqN nextSqN;

    logic isDiv;
    logic srcPending;
    logic portBlocked;
    logic accept;
    logic [`XLEN-1:0] immExt;

    //////////////////////////////
    // issue decision
    //////////////////////////////

    always_comb begin
        isDiv = inUOp.opcode inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        srcPending = pending[inUOp.src1] || (!inUOp.useImm && pending[inUOp.src2]);
        portBlocked = isDiv ? portStatus.divBusy : portStatus.wbReserved;
        inStall = robFull || srcPending || pending[inUOp.dst] || portBlocked;
        accept = inUOp.valid && !inStall;
        immExt = {{(`XLEN-12){inUOp.imm[11]}}, inUOp.imm};
    end

    //////////////////////////////
    // register file and scoreboard
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (retireValid && retireUOp.dst != '0) begin
            regFile[retireUOp.dst] <= retireUOp.result;  // r0 never written
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= '0;
            nextSqN <= '0;
        end else begin
            if (retireValid) begin
                pending[retireUOp.dst] <= 1'b0;
            end
            if (accept) begin
                if (inUOp.dst != '0) begin
                    pending[inUOp.dst] <= 1'b1;
                end
                nextSqN <= nextSqN + 1'b1;
            end
        end
    end

    //////////////////////////////
    // issue register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueUOp.valid <= 1'b0;
        end else begin
            issueUOp.valid <= accept;
            if (accept) begin
                issueUOp.opcode <= inUOp.opcode;
                issueUOp.sqN <= nextSqN;
                issueUOp.dst <= inUOp.dst;
                issueUOp.opA <= regFile[inUOp.src1];
                issueUOp.opB <= inUOp.useImm ? immExt : regFile[inUOp.src2];
            end
        end
    end

endmodule

//--- reorderBuffer.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reorderBuffer
(
    input logic clk,
    input logic rstN,

    input corePkg::IssueUOp issueUOp,
    input corePkg::ResultUOp result,
    output logic robFull,

    output logic retireValid,
    output corePkg::CommitUOp retireUOp,

    output logic commitValid,
    output corePkg::CommitUOp commitUOp,
    input logic commitStall
);
    import corePkg::*;

    typedef logic [$clog2(`ROB_SIZE)-1:0] RobIdx;

    logic [`ROB_SIZE-1:0] complete;
    RegIdx entryDst [`ROB_SIZE];
    logic [`XLEN-1:0] entryRes [`ROB_SIZE];
    SqN head;  // oldest unretired
    SqN tail;

    SqN used;
    RobIdx headIdx;
    RobIdx issueIdx;
    RobIdx resultIdx;
    logic canRetire;

    always_comb begin
        used = tail - head;
        // count the op sitting in the issue register as well
        robFull = (used == SqN'(`ROB_SIZE))
            || (issueUOp.valid && used == SqN'(`ROB_SIZE - 1));
        headIdx = head[$bits(RobIdx)-1:0];
        issueIdx = issueUOp.sqN[$bits(RobIdx)-1:0];
        resultIdx = result.sqN[$bits(RobIdx)-1:0];
        canRetire = (head != tail) && complete[headIdx] && (!commitValid || !commitStall);
        retireValid = canRetire;
        retireUOp.sqN = head;
        retireUOp.dst = entryDst[headIdx];
        retireUOp.result = entryRes[headIdx];
    end

    //////////////////////////////
    // entry payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (issueUOp.valid) begin
            entryDst[issueIdx] <= issueUOp.dst;
        end
        if (result.valid) begin
            entryRes[resultIdx] <= result.result;
        end
    end

    //////////////////////////////
    // pointers and commit register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            complete <= '0;
            commitValid <= 1'b0;
        end else begin
            if (issueUOp.valid) begin
                tail <= tail + 1'b1;
                complete[issueIdx] <= 1'b0;
            end
            if (result.valid) begin
                complete[resultIdx] <= 1'b1;
            end
            if (canRetire) begin
                complete[headIdx] <= 1'b0;
                head <= head + 1'b1;
                commitValid <= 1'b1;
                commitUOp <= retireUOp;
            end else if (!commitStall) begin
                commitValid <= 1'b0;  // taken, nothing new
            end
        end
    end

endmodule

//--- miniCore.sv
`timescale 1ns/1ps

module miniCore
(
    input logic clk,
    input logic rstN,

    input corePkg::InUOp inUOp,
    output logic inStall,

    output logic commitValid,
    output corePkg::CommitUOp commitUOp,
    input logic commitStall
);
    import corePkg::*;

    IssueUOp issueUOp;
    PortStatus portStatus;
    ResultUOp result;
    CommitUOp retireUOp;
    logic robFull;
    logic retireValid;

    dispatchStage dispatch_i
    (
        .clk(clk),
        .rstN(rstN),
        .inUOp(inUOp),
        .inStall(inStall),
        .portStatus(portStatus),
        .robFull(robFull),
        .retireValid(retireValid),
        .retireUOp(retireUOp),
        .issueUOp(issueUOp)
    );

    execPort exec_i
    (
        .clk(clk),
        .rstN(rstN),
        .issueUOp(issueUOp),
        .portStatus(portStatus),
        .result(result)
    );

    reorderBuffer rob_i
    (
        .clk(clk),
        .rstN(rstN),
        .issueUOp(issueUOp),
        .result(result),
        .robFull(robFull),
        .retireValid(retireValid),
        .retireUOp(retireUOp),
        .commitValid(commitValid),
        .commitUOp(commitUOp),
        .commitStall(commitStall)
    );

endmodule

//--- miniCoreTb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module miniCoreTb;
    import corePkg::*;

    localparam int NUM_OPS = 300;
    localparam int TIMEOUT = NUM_OPS * (`DIV_CYCLES + 4);
    localparam int LONG_STALL = 200;

    logic clk;
    logic rstN;
    InUOp inUOp;
    logic inStall;
    logic commitValid;
    CommitUOp commitUOp;
    logic commitStall;

    logic [`XLEN-1:0] modelRegs [`NUM_REGS];  // program order view
    RegIdx expDst [$];
    logic [`XLEN-1:0] expRes [$];
    logic expIsDiv [$];
    SqN expSqN;
    int accepts;
    int commits;
    int cycles;
    int stallCycles;
    logic seenAccept;
    logic sawStall;

    miniCore miniCore_i (
        .clk(clk),
        .rstN(rstN),
        .inUOp(inUOp),
        .inStall(inStall),
        .commitValid(commitValid),
        .commitUOp(commitUOp),
        .commitStall(commitStall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic failCheck(input string msg);
        stopRun($sformatf("[FAIL] %0t: %s", $time, msg));
    endtask

    // expected value from the ALU and divider rules
    function automatic logic [`XLEN-1:0] refResult(
        input Opcode op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [`XLEN-1:0] minVal;
        minVal = {1'b1, {(`XLEN-1){1'b0}}};
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLL: return a << b[4:0];
            OP_SRL: return a >> b[4:0];
            OP_SRA: return $signed(a) >>> b[4:0];
            OP_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_SLTU: return (a < b) ? 1 : 0;
            OP_DIV: begin
                if (b == '0) return '1;
                if (a == minVal && b == '1) return minVal;
                return $signed(a) / $signed(b);
            end
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) return a;
                if (a == minVal && b == '1) return '0;
                return $signed(a) % $signed(b);
            end
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic InUOp makeOp(
        input Opcode op,
        input int dst,
        input int src1,
        input int src2,
        input logic useImm,
        input logic [11:0] imm
    );
        InUOp u;
        u.valid = 1'b1;
        u.opcode = op;
        u.dst = RegIdx'(dst);
        u.src1 = RegIdx'(src1);
        u.src2 = RegIdx'(src2);
        u.useImm = useImm;
        u.imm = imm;
        return u;
    endfunction

    function automatic InUOp randomOp();
        Opcode op;
        logic useImm;
        logic [11:0] imm;
        int pick;
        useImm = ($urandom % 2) == 0;
        imm = 12'($urandom);
        if (($urandom % 4) == 0) begin
            op = Opcode'(4'(10 + $urandom % 4));
            pick = $urandom % 3;
            if (useImm && pick == 0) imm = 12'h000;  // zero divisor
            if (useImm && pick == 1) imm = 12'hfff;  // minus one
        end else begin
            op = Opcode'(4'($urandom % 10));
        end
        return makeOp(op, $urandom % 8, $urandom % 8, $urandom % 8, useImm, imm);
    endfunction

    // hold the op until an edge accepts it
    task automatic sendOp(input InUOp u);
        inUOp <= u;
        @(posedge clk);
        while (inStall) @(posedge clk);
    endtask

    ////////////////////////////////
    // reference model
    ////////////////////////////////

    always @(posedge clk) begin : acceptModel
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] r;
        logic signed [`XLEN-1:0] immVal;
        if (rstN && inUOp.valid && !inStall) begin
            immVal = $signed(inUOp.imm);
            a = modelRegs[inUOp.src1];
            b = inUOp.useImm ? immVal : modelRegs[inUOp.src2];
            r = refResult(inUOp.opcode, a, b);
            if (inUOp.dst != '0) modelRegs[inUOp.dst] = r;
            expDst.push_back(inUOp.dst);
            expRes.push_back(r);
            expIsDiv.push_back(inUOp.opcode inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});
            accepts++;
            seenAccept = 1'b1;
        end
    end

    always @(posedge clk) begin : commitCheck
        RegIdx d;
        logic [`XLEN-1:0] r;
        logic isDiv;
        if (rstN && !seenAccept) begin
            assert (!inStall && !commitValid) else failCheck("busy before first accept");
        end
        if (rstN && commitValid && !commitStall) begin
            assert (expDst.size() > 0) else failCheck("commit with no op outstanding");
            d = expDst.pop_front();
            r = expRes.pop_front();
            isDiv = expIsDiv.pop_front();
            assert (commitUOp.sqN == expSqN)
                else failCheck($sformatf("sqN %0d, expected %0d", commitUOp.sqN, expSqN));
            assert (commitUOp.dst == d)
                else failCheck($sformatf("dst %0d, expected %0d", commitUOp.dst, d));
            if (isDiv) begin
                assert (commitUOp.result == r)
                    else failCheck($sformatf("div result %h, expected %h", commitUOp.result, r));
            end else begin
                assert (commitUOp.result == r)
                    else failCheck($sformatf("alu result %h, expected %h", commitUOp.result, r));
            end
            expSqN = expSqN + 1'b1;
            commits++;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (commitValid && commitStall) |=> (commitValid && $stable(commitUOp)))
        else failCheck("commit output changed while stalled");

    ////////////////////////////////
    // commit back-pressure and timeout
    ////////////////////////////////

    always @(posedge clk) begin
        if (accepts >= NUM_OPS / 2 && stallCycles < LONG_STALL) begin
            commitStall <= 1'b1;  // long stall fills the buffer
            stallCycles++;
            if (inUOp.valid && inStall) sawStall = 1'b1;
        end else begin
            commitStall <= ($urandom % 10) < 3;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT + LONG_STALL) begin
            stopRun("timeout: not all micro-ops committed within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h8009054b));
        rstN = 1'b0;
        inUOp = '0;
        commitStall = 1'b0;
        expSqN = '0;
        accepts = 0;
        commits = 0;
        cycles = 0;
        stallCycles = 0;
        seenAccept = 1'b0;
        sawStall = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) modelRegs[i] = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);
        // most negative dividend against minus one
        sendOp(makeOp(OP_ADD, 1, 0, 0, 1'b1, 12'd1));
        sendOp(makeOp(OP_SLL, 2, 1, 0, 1'b1, 12'd31));
        sendOp(makeOp(OP_DIV, 3, 2, 0, 1'b1, 12'hfff));
        sendOp(makeOp(OP_REM, 4, 2, 0, 1'b1, 12'hfff));
        for (int n = 4; n < NUM_OPS; n++) begin
            sendOp(randomOp());
        end
        inUOp <= '0;
        while (commits != NUM_OPS) @(posedge clk);
        repeat (2) @(posedge clk);
        if (commits == accepts && accepts == NUM_OPS && expDst.size() == 0 && sawStall) begin
            $display("No errors");
            $finish;
        end else begin
            stopRun("commit count or long stall behavior does not match the accepted ops");
        end
    end

endmodule

//--- miniCore.f
+incdir+.
corePkg.sv
intAlu.sv
divider.sv
execPort.sv
dispatchStage.sv
reorderBuffer.sv
miniCore.sv
miniCoreTb.sv

//--- run.sh
#!/bin/sh
# compile and run the miniCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module miniCoreTb -f miniCore.f -o miniCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit $status
fi

./obj_dir/miniCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
